// File: Makefile
VERILATOR ?= verilator
TOP ?= nnLayer_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/nnLayerScoreboard.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module nnLayerScoreboard
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`NN_ADR_W-1:0] adr,
	input wire [31:0] datR,
	input wire ack,
	input wire checkEn,
	input wire [31:0] expData,
	output int checkCount,
	output int errorCount
);

	// Compared on the edge that closes the ack cycle
	always @(posedge clk)
	begin
		if (reset)
		begin
			checkCount <= 0;
			errorCount <= 0;
		end
		else if (cyc && stb && !we && ack && checkEn)
		begin
			checkCount <= checkCount + 1;
			if (datR !== expData)
			begin
				errorCount <= errorCount + 1;
				$display("[ERROR] %0t ns: %s read at 0x%03h gave 0x%08h, expected 0x%08h",
					$time, adr == `NN_ADR_CTRL ? "status" : "data", adr, datR, expData);
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/nnLayer_chk.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module nnLayer_chk
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire ack,
	input wire start,
	input wire busy,
	input wire sumValid
);

	// A fresh request is answered on the next cycle, for one cycle only
	ackOnePulse: assert property (@(posedge clk) disable iff (reset)
		(cyc && stb && !ack) |=> ack ##1 !ack)
		else $error("ack did not follow the request as a single-cycle pulse");

	startLaunches: assert property (@(posedge clk) disable iff (reset) start |=> busy)
		else $error("start pulsed but the engine did not go busy");

	// Bias cycle plus all inputs before the first neuron finishes
	firstSumTiming: assert property (@(posedge clk) disable iff (reset)
		start |=> !sumValid [*`NN_INPUTS] ##1 sumValid)
		else $error("sumValid of the first neuron came at the wrong cycle");

endmodule

bind nnLayer nnLayer_chk nnLayer_chk_inst
(
	.clk(clk),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.start(start),
	.busy(busy),
	.sumValid(sumValid)
);

`default_nettype wire

// File: dv/nnLayer_stim.txt
// Records: 1 write (adr count data...), 2 random write (adr), 3 read check (adr count exp...)
// 4 start, 5 poll until done, 0 end; all values hex
3 000 1 0
3 240 4 0 0 0 0
// Run 1, weights and biases stay loaded for run 2
1 100 4 2000 2000 2000 2000
1 108 1 ffffe000
1 114 3 10000 2000 ffffa000
1 119 1 2000
1 200 4 bfff 1000 4000 20002000
1 040 7 1 2 3 4 10000 5 ffffffff
2 047
4
3 000 1 1
// Second start and writes while busy are dropped
4
1 041 1 100
1 119 1 4000
3 000 1 1
5
3 000 1 2
3 240 4 f 0 a 3
// Unmapped words
3 048 1 0
3 244 1 0
3 3ff 1 0
// Run 2 with new inputs
1 040 7 fffffffd 6 7 8 1 2 1
2 047
4
3 000 1 1
5
3 000 1 2
3 240 4 17 3 9 7
0

// File: dv/nnLayer_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module nnLayer_tb;

	localparam int driveDelay = 1;
	localparam int stimWords = 512;
	localparam int runCycles = `NN_NEURONS * (`NN_INPUTS + 1) + 2;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [`NN_ADR_W-1:0] adr;
	logic [31:0] datW;
	logic [31:0] datR;
	logic ack;
	logic checkEn;
	logic [31:0] expData;
	int checkCount;
	int errorCount;
	int stimErrors;
	int cycleCount = 0;
	int cycleLimit = 0;
	integer seed;
	logic [31:0] stim [stimWords];
	int ptr;

	nnLayer nnLayer_inst (.*);

	nnLayerScoreboard nnLayerScoreboard_inst (.*);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Checks: %0d, errors: %0d, stim errors: %0d", checkCount, errorCount,
				stimErrors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Cycles each record needs, with reset and the closing idle cycles
	function automatic int recordCycles();
		int p;
		int total;
		p = 0;
		total = 4 + 2;
		while (p < stimWords && stim[p] != 0)
		begin
			case (stim[p])
				1, 3:
				begin
					total += 3 * int'(stim[p + 2]);
					p += 3 + int'(stim[p + 2]);
				end
				2:
				begin
					total += 3;
					p += 2;
				end
				4:
				begin
					total += 3;
					p += 1;
				end
				5:
				begin
					total += runCycles + 3;
					p += 1;
				end
				default: p += 1;
			endcase
		end
		return total;
	endfunction

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	task automatic waitAck();
		do
		begin
			@(posedge clk);
			#driveDelay;
		end while (!ack);
	endtask

	// Hold the request through the ack cycle, then leave one idle cycle
	task automatic busAccess(input logic write, input logic [`NN_ADR_W-1:0] a,
		input logic [31:0] d, output logic [31:0] q);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a;
		datW = d;
		waitAck();
		q = datR; // Read data is valid while ack is high
		@(posedge clk);
		#driveDelay;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		checkEn = 1'b0;
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic pollDone();
		logic [31:0] status;
		status = '0;
		while (!status[1])
			busAccess(1'b0, `NN_ADR_CTRL, '0, status);
	endtask

	initial
	begin
		logic [31:0] rd;
		int n;
		clk = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datW = '0;
		checkEn = 1'b0;
		expData = '0;
		stimErrors = 0;
		seed = 56;
		$readmemh("dv/nnLayer_stim.txt", stim);
		cycleLimit = 4 * recordCycles();
		repeat (4) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		ptr = 0;
		while (ptr < stimWords && stim[ptr] != 0)
		begin
			n = int'(stim[ptr + 2]);
			case (stim[ptr])
				1, 3:
				begin
					for (int i = 0; i < n; i++)
					begin
						checkEn = stim[ptr] == 3;
						expData = stim[ptr + 3 + i];
						busAccess(stim[ptr] == 1, `NN_ADR_W'(stim[ptr + 1] + i),
							stim[ptr + 3 + i], rd);
					end
					ptr += 3 + n;
				end
				2:
				begin
					busAccess(1'b1, `NN_ADR_W'(stim[ptr + 1]), $random(seed), rd); // Zero weight
					ptr += 2;
				end
				4:
				begin
					busAccess(1'b1, `NN_ADR_CTRL, 32'd1, rd);
					ptr += 1;
				end
				5:
				begin
					pollDone();
					ptr += 1;
				end
				default:
				begin
					$display("Unknown stim record %0h at word %0d, stimulus stopped", stim[ptr], ptr);
					stimErrors++;
					ptr = stimWords;
				end
			endcase
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d, stim errors: %0d", checkCount, errorCount,
			stimErrors);
		if (errorCount == 0 && stimErrors == 0 && checkCount > 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/nnLayerPkg.sv
rtl/busDecode.sv
rtl/paramStore.sv
rtl/macEngine.sv
rtl/reluQuant.sv
rtl/nnLayer.sv
dv/nnLayerScoreboard.sv
dv/nnLayer_chk.sv
dv/nnLayer_tb.sv

// File: rtl/busDecode.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module busDecode
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`NN_ADR_W-1:0] adr,
	input wire [31:0] datW,
	input wire busy,
	input wire runDone,
	input wire nnLayerPkg::outWordT outData,
	output logic [31:0] datR,
	output logic ack,
	output nnLayerPkg::regionT wrRegion,
	output logic [$clog2(`NN_WEIGHTS)-1:0] wrIndex,
	output nnLayerPkg::dataWordT wrData,
	output logic wrEn,
	output logic [$clog2(`NN_NEURONS)-1:0] rdIndex,
	output logic start
);

	localparam int neuW = $clog2(`NN_NEURONS);
	localparam int idxW = $clog2(`NN_WEIGHTS);

	// First word past each region
	localparam logic [`NN_ADR_W-1:0] inputEnd = `NN_ADR_INPUT + `NN_INPUTS;
	localparam logic [`NN_ADR_W-1:0] weightEnd = `NN_ADR_WEIGHT + `NN_WEIGHTS;
	localparam logic [`NN_ADR_W-1:0] biasEnd = `NN_ADR_BIAS + `NN_NEURONS;
	localparam logic [`NN_ADR_W-1:0] outputEnd = `NN_ADR_OUTPUT + `NN_NEURONS;

	nnLayerPkg::regionT region;
	logic [`NN_ADR_W-1:0] offset;
	logic request;
	logic done;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	always_comb
	begin
		region = nnLayerPkg::regionNone;
		offset = '0;
		if (adr == `NN_ADR_CTRL)
			region = nnLayerPkg::regionCtrl;
		else if (adr >= `NN_ADR_INPUT && adr < inputEnd)
		begin
			region = nnLayerPkg::regionInput;
			offset = adr - `NN_ADR_INPUT;
		end
		else if (adr >= `NN_ADR_WEIGHT && adr < weightEnd)
		begin
			region = nnLayerPkg::regionWeight;
			offset = adr - `NN_ADR_WEIGHT;
		end
		else if (adr >= `NN_ADR_BIAS && adr < biasEnd)
		begin
			region = nnLayerPkg::regionBias;
			offset = adr - `NN_ADR_BIAS;
		end
		else if (adr >= `NN_ADR_OUTPUT && adr < outputEnd)
		begin
			region = nnLayerPkg::regionOutput;
			offset = adr - `NN_ADR_OUTPUT;
		end
	end

	assign request = cyc && stb;

	// One-cycle ack, never back to back
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= request && !ack;
	end

	// Storage writes land on the edge that ends the ack cycle
	assign wrRegion = region;
	assign wrIndex = idxW'(offset);
	assign wrData = datW;
	assign wrEn = ack && request && we && !busy &&
		(region inside {nnLayerPkg::regionInput, nnLayerPkg::regionWeight,
		nnLayerPkg::regionBias});

	assign start = ack && request && we && !busy && datW[0] &&
		region == nnLayerPkg::regionCtrl; // Ignored while a run is going

	always_ff @(posedge clk)
	begin
		if (reset)
			done <= 1'b0;
		else if (start)
			done <= 1'b0; // A new run hides the old completion
		else if (runDone)
			done <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////

	assign rdIndex = neuW'(offset);

	always_comb
	begin
		datR = '0;
		case (region)
			nnLayerPkg::regionCtrl: datR = {30'b0, done, busy};
			nnLayerPkg::regionOutput: datR = 32'(outData);
			default: datR = '0; // Unmapped and write-only words read zero
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/macEngine.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module macEngine
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire nnLayerPkg::dataWordT inputWord,
	input wire nnLayerPkg::dataWordT weightWord,
	input wire nnLayerPkg::dataWordT biasWord,
	output logic busy,
	output logic [$clog2(`NN_NEURONS)-1:0] rdNeuron,
	output logic [$clog2(`NN_INPUTS)-1:0] rdInput,
	output logic sumValid,
	output logic [$clog2(`NN_NEURONS)-1:0] sumNeuron,
	output nnLayerPkg::dataWordT sum
);

	localparam int inW = $clog2(`NN_INPUTS);
	localparam int neuW = $clog2(`NN_NEURONS);

	typedef enum logic [1:0]
	{
		stateIdle,
		stateBias,
		stateAcc
	} stateT;

	stateT state;
	logic [neuW-1:0] neuronCnt;
	logic [inW-1:0] inputCnt;
	nnLayerPkg::dataWordT acc;
	nnLayerPkg::dataWordT product;
	logic lastInput;
	logic lastNeuron;

	//////////////////////////////////////////////////
	// Datapath, one product per cycle
	//////////////////////////////////////////////////

	assign product = inputWord * weightWord; // Low 32 bits only
	assign sum = acc + product; // Wraps like the parallel adder tree

	assign lastInput = inputCnt == inW'(`NN_INPUTS - 1);
	assign lastNeuron = neuronCnt == neuW'(`NN_NEURONS - 1);

	assign busy = state != stateIdle;
	assign sumValid = state == stateAcc && lastInput; // Final add of the neuron
	assign sumNeuron = neuronCnt;
	assign rdNeuron = neuronCnt;
	assign rdInput = inputCnt;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			neuronCnt <= '0;
			inputCnt <= '0;
			acc <= '0;
		end
		else
		begin
			case (state)
				stateIdle:
				begin
					if (start)
					begin
						state <= stateBias;
						neuronCnt <= '0;
						inputCnt <= '0;
					end
				end
				stateBias:
				begin
					acc <= biasWord; // Accumulator starts from the bias
					inputCnt <= '0;
					state <= stateAcc;
				end
				stateAcc:
				begin
					acc <= sum;
					if (lastInput)
					begin
						inputCnt <= '0;
						if (lastNeuron)
							state <= stateIdle;
						else
						begin
							neuronCnt <= neuronCnt + 1'b1;
							state <= stateBias;
						end
					end
					else
						inputCnt <= inputCnt + 1'b1;
				end
				default: state <= stateIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/nnLayer.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module nnLayer
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`NN_ADR_W-1:0] adr,
	input wire [31:0] datW,
	output logic [31:0] datR,
	output logic ack
);

	nnLayerPkg::regionT wrRegion;
	logic [$clog2(`NN_WEIGHTS)-1:0] wrIndex;
	nnLayerPkg::dataWordT wrData;
	logic wrEn;
	logic [$clog2(`NN_NEURONS)-1:0] rdIndex;
	nnLayerPkg::outWordT outData;
	logic start;
	logic busy;
	logic runDone;
	logic [$clog2(`NN_NEURONS)-1:0] rdNeuron;
	logic [$clog2(`NN_INPUTS)-1:0] rdInput;
	nnLayerPkg::dataWordT inputWord;
	nnLayerPkg::dataWordT weightWord;
	nnLayerPkg::dataWordT biasWord;
	logic sumValid;
	logic [$clog2(`NN_NEURONS)-1:0] sumNeuron;
	nnLayerPkg::dataWordT sum;

	busDecode busDecode_inst
	(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datW(datW),
		.busy(busy),
		.runDone(runDone),
		.outData(outData),
		.datR(datR),
		.ack(ack),
		.wrRegion(wrRegion),
		.wrIndex(wrIndex),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdIndex(rdIndex),
		.start(start)
	);

	paramStore paramStore_inst
	(
		.clk(clk),
		.reset(reset),
		.wrRegion(wrRegion),
		.wrIndex(wrIndex),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdNeuron(rdNeuron),
		.rdInput(rdInput),
		.inputWord(inputWord),
		.weightWord(weightWord),
		.biasWord(biasWord)
	);

	macEngine macEngine_inst
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.inputWord(inputWord),
		.weightWord(weightWord),
		.biasWord(biasWord),
		.busy(busy),
		.rdNeuron(rdNeuron),
		.rdInput(rdInput),
		.sumValid(sumValid),
		.sumNeuron(sumNeuron),
		.sum(sum)
	);

	reluQuant reluQuant_inst
	(
		.clk(clk),
		.reset(reset),
		.sumValid(sumValid),
		.sumNeuron(sumNeuron),
		.sum(sum),
		.rdIndex(rdIndex),
		.outData(outData),
		.runDone(runDone)
	);

endmodule

`default_nettype wire

// File: rtl/nnLayerPkg.sv
`default_nettype none
`include "nnLayer_cfg.svh"

package nnLayerPkg;

	// Two's-complement word for inputs, weights, biases and sums
	typedef logic signed [31:0] dataWordT;

	typedef logic [`NN_OUT_MSB-`NN_OUT_LSB:0] outWordT; // Rectified output

	// Address regions seen by the bus decoder
	typedef enum logic [2:0]
	{
		regionCtrl,
		regionInput,
		regionWeight,
		regionBias,
		regionOutput,
		regionNone
	} regionT;

endpackage

`default_nettype wire

// File: rtl/nnLayer_cfg.svh
`ifndef NN_LAYER_CFG_SVH
`define NN_LAYER_CFG_SVH

//////////////////////////////////////////////////
// Layer geometry
//////////////////////////////////////////////////

`define NN_INPUTS 8
`define NN_NEURONS 4
`define NN_WEIGHTS (`NN_INPUTS * `NN_NEURONS)

// Sum bits kept by the rectifier, same window as the single neuron
`define NN_OUT_MSB 28
`define NN_OUT_LSB 13

//////////////////////////////////////////////////
// Word address map
//////////////////////////////////////////////////

`define NN_ADR_W 10
`define NN_ADR_CTRL 10'h000
`define NN_ADR_INPUT 10'h040
`define NN_ADR_WEIGHT 10'h100 // Neuron-major
`define NN_ADR_BIAS 10'h200
`define NN_ADR_OUTPUT 10'h240

`endif

// File: rtl/paramStore.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module paramStore
(
	input wire clk,
	input wire reset,
	input wire nnLayerPkg::regionT wrRegion,
	input wire [$clog2(`NN_WEIGHTS)-1:0] wrIndex,
	input wire nnLayerPkg::dataWordT wrData,
	input wire wrEn,
	input wire [$clog2(`NN_NEURONS)-1:0] rdNeuron,
	input wire [$clog2(`NN_INPUTS)-1:0] rdInput,
	output nnLayerPkg::dataWordT inputWord,
	output nnLayerPkg::dataWordT weightWord,
	output nnLayerPkg::dataWordT biasWord
);

	localparam int inW = $clog2(`NN_INPUTS);
	localparam int neuW = $clog2(`NN_NEURONS);
	localparam int idxW = $clog2(`NN_WEIGHTS);

	nnLayerPkg::dataWordT inputMem [`NN_INPUTS];
	nnLayerPkg::dataWordT weightMem [`NN_WEIGHTS];
	nnLayerPkg::dataWordT biasMem [`NN_NEURONS];

	logic [idxW-1:0] weightAddr;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputMem <= '{default: '0};
			weightMem <= '{default: '0};
			biasMem <= '{default: '0};
		end
		else if (wrEn)
		begin
			case (wrRegion)
				nnLayerPkg::regionInput: inputMem[wrIndex[inW-1:0]] <= wrData;
				nnLayerPkg::regionWeight: weightMem[wrIndex] <= wrData;
				nnLayerPkg::regionBias: biasMem[wrIndex[neuW-1:0]] <= wrData;
				default: ;
			endcase
		end
	end

	// Row n of the weight matrix starts at n times the input count
	assign weightAddr = idxW'(rdNeuron) * idxW'(`NN_INPUTS) + idxW'(rdInput);

	assign inputWord = inputMem[rdInput];
	assign weightWord = weightMem[weightAddr];
	assign biasWord = biasMem[rdNeuron];

endmodule

`default_nettype wire

// File: rtl/reluQuant.sv
`timescale 1ns/1ns
`default_nettype none
`include "nnLayer_cfg.svh"

module reluQuant
(
	input wire clk,
	input wire reset,
	input wire sumValid,
	input wire [$clog2(`NN_NEURONS)-1:0] sumNeuron,
	input wire nnLayerPkg::dataWordT sum,
	input wire [$clog2(`NN_NEURONS)-1:0] rdIndex,
	output nnLayerPkg::outWordT outData,
	output logic runDone
);

	localparam int neuW = $clog2(`NN_NEURONS);

	nnLayerPkg::outWordT outPend [`NN_NEURONS]; // Filled as neurons finish
	nnLayerPkg::outWordT outVis [`NN_NEURONS]; // What the host sees
	nnLayerPkg::outWordT quant;

	// Negative sums clamp to zero, others keep the fixed-point window
	assign quant = sum[31] ? '0 : sum[`NN_OUT_MSB:`NN_OUT_LSB];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outPend <= '{default: '0};
			outVis <= '{default: '0};
			runDone <= 1'b0;
		end
		else
		begin
			runDone <= sumValid && sumNeuron == neuW'(`NN_NEURONS - 1);
			if (sumValid)
				outPend[sumNeuron] <= quant;
			if (runDone)
				outVis <= outPend; // Whole run becomes visible at once
		end
	end

	assign outData = outVis[rdIndex];

endmodule

`default_nettype wire
